// ==== rtl/redirect_pkg.sv ====
package redirect_pkg;

    // Datapath and field widths
    localparam int XLEN        = 32;
    localparam int REG_NUM_W   = 5;
    localparam int CSR_ADDR_W  = 14;
    localparam int ECODE_W     = 6;

    // Eight external interrupt lines
    localparam int INT_NUM     = 8;

    // Branch lanes and writeback lanes
    localparam int ISSUE_WIDTH = 2;

    // CSR address map
    localparam logic [CSR_ADDR_W-1:0] CSR_CRMD      = 14'h000;
    localparam logic [CSR_ADDR_W-1:0] CSR_PRMD      = 14'h001;
    localparam logic [CSR_ADDR_W-1:0] CSR_ECFG      = 14'h004;
    localparam logic [CSR_ADDR_W-1:0] CSR_ESTAT     = 14'h005;
    localparam logic [CSR_ADDR_W-1:0] CSR_ERA       = 14'h006;
    localparam logic [CSR_ADDR_W-1:0] CSR_EENTRY    = 14'h00c;
    localparam logic [CSR_ADDR_W-1:0] CSR_TLBRENTRY = 14'h088;

    // Interrupts are reported with code zero
    localparam logic [ECODE_W-1:0] ECODE_INT = 6'h00;

    // ESTAT layout
    // Pending interrupt lines start at bit 2
    localparam int ESTAT_IS_LSB    = 2;
    // Exception code in bits 21:16
    localparam int ESTAT_ECODE_LSB = 16;

    // CRMD and PRMD share one layout
    // In PRMD the fields hold the saved level and enable
    typedef union packed {
        logic [XLEN-1:0] raw;
        struct packed {
            logic [XLEN-4:0] rsvd;
            logic            ie;
            logic [1:0]      plv;
        } fields;
    } mode_word_u;

endpackage

// ==== rtl/redirect_csr.sv ====
`timescale 1ns/10ps

module redirect_csr (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic [redirect_pkg::INT_NUM-1:0]    intrpt_i,
    input  logic                                excp_take_i,
    input  logic                                ertn_take_i,
    input  logic [redirect_pkg::ECODE_W-1:0]    excp_ecode_i,
    input  logic [redirect_pkg::XLEN-1:0]       excp_pc_i,
    input  logic                                csr_we_i,
    input  logic [redirect_pkg::CSR_ADDR_W-1:0] csr_waddr_i,
    input  logic [redirect_pkg::XLEN-1:0]       csr_wdata_i,
    input  logic [redirect_pkg::CSR_ADDR_W-1:0] csr_raddr_i,
    output logic [redirect_pkg::XLEN-1:0]       csr_rdata_o,
    output logic                                has_int_o,
    output logic [redirect_pkg::XLEN-1:0]       eentry_o,
    output logic [redirect_pkg::XLEN-1:0]       tlbrentry_o,
    output logic [redirect_pkg::XLEN-1:0]       era_o,
    output logic [1:0]                          plv_o
);

    import redirect_pkg::*;

    mode_word_u          crmd;
    mode_word_u          prmd;
    logic [INT_NUM-1:0]  ecfg_lie;
    logic [ECODE_W-1:0]  estat_ecode;
    logic [XLEN-1:0]     era;
    logic [XLEN-1:0]     eentry;
    logic [XLEN-1:0]     tlbrentry;
    logic [XLEN-1:0]     estat_word;

    // Only PLV and IE survive a software write to a mode word
    function automatic mode_word_u mask_mode(input logic [XLEN-1:0] wdata);
        mode_word_u in_word;
        mode_word_u out_word;
        in_word.raw            = wdata;
        out_word.fields.rsvd   = '0;
        out_word.fields.ie     = in_word.fields.ie;
        out_word.fields.plv    = in_word.fields.plv;
        return out_word;
    endfunction

    // Takes win over software writes in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            crmd.raw    <= '0;
            prmd.raw    <= '0;
            ecfg_lie    <= '0;
            estat_ecode <= '0;
            era         <= '0;
            eentry      <= '0;
            tlbrentry   <= '0;
        end else if (excp_take_i) begin
            era              <= excp_pc_i;
            prmd.fields.plv  <= crmd.fields.plv;
            prmd.fields.ie   <= crmd.fields.ie;
            crmd.fields.plv  <= 2'b00;
            crmd.fields.ie   <= 1'b0;
            estat_ecode      <= excp_ecode_i;
        end else if (ertn_take_i) begin
            crmd.fields.plv  <= prmd.fields.plv;
            crmd.fields.ie   <= prmd.fields.ie;
        end else if (csr_we_i) begin
            case (csr_waddr_i)
                CSR_CRMD:      crmd      <= mask_mode(csr_wdata_i);
                CSR_PRMD:      prmd      <= mask_mode(csr_wdata_i);
                CSR_ECFG:      ecfg_lie  <= csr_wdata_i[INT_NUM-1:0];
                CSR_ERA:       era       <= csr_wdata_i;
                CSR_EENTRY:    eentry    <= csr_wdata_i;
                CSR_TLBRENTRY: tlbrentry <= csr_wdata_i;
                // ESTAT and unmapped addresses ignore writes
                default: ;
            endcase
        end
    end

    // ESTAT shows the live lines next to the latched code
    always_comb begin
        estat_word = '0;
        estat_word[ESTAT_IS_LSB +: INT_NUM]    = intrpt_i;
        estat_word[ESTAT_ECODE_LSB +: ECODE_W] = estat_ecode;
    end

    always_comb begin
        case (csr_raddr_i)
            CSR_CRMD:      csr_rdata_o = crmd.raw;
            CSR_PRMD:      csr_rdata_o = prmd.raw;
            CSR_ECFG:      csr_rdata_o = {{(XLEN-INT_NUM){1'b0}}, ecfg_lie};
            CSR_ESTAT:     csr_rdata_o = estat_word;
            CSR_ERA:       csr_rdata_o = era;
            CSR_EENTRY:    csr_rdata_o = eentry;
            CSR_TLBRENTRY: csr_rdata_o = tlbrentry;
            default:       csr_rdata_o = '0;
        endcase
    end

    // Pending level gated by the global enable and the per-line mask
    assign has_int_o = crmd.fields.ie & (|(intrpt_i & ecfg_lie));

    assign eentry_o    = eentry;
    assign tlbrentry_o = tlbrentry;
    assign era_o       = era;
    assign plv_o       = crmd.fields.plv;

endmodule

// ==== rtl/redirect_sel.sv ====
`timescale 1ns/10ps

module redirect_sel (
    input  logic [redirect_pkg::ISSUE_WIDTH-1:0] branch_taken_i,
    input  logic [redirect_pkg::XLEN-1:0]        branch_target0_i,
    input  logic [redirect_pkg::XLEN-1:0]        branch_target1_i,
    input  logic                                 excp_valid_i,
    input  logic [redirect_pkg::ECODE_W-1:0]     excp_ecode_i,
    input  logic                                 excp_tlbrefill_i,
    input  logic                                 ertn_i,
    input  logic                                 has_int_i,
    input  logic [redirect_pkg::XLEN-1:0]        eentry_i,
    input  logic [redirect_pkg::XLEN-1:0]        tlbrentry_i,
    input  logic [redirect_pkg::XLEN-1:0]        era_i,
    output logic [redirect_pkg::XLEN-1:0]        next_pc_o,
    output logic                                 flush_o,
    output logic                                 excp_take_o,
    output logic                                 ertn_take_o,
    output logic [redirect_pkg::ECODE_W-1:0]     excp_ecode_o,
    output logic                                 lane1_kill_o
);

    import redirect_pkg::*;

    // Branches first, then exception, then return
    always_comb begin
        next_pc_o    = '0;
        flush_o      = 1'b0;
        excp_take_o  = 1'b0;
        ertn_take_o  = 1'b0;
        lane1_kill_o = branch_taken_i[0];
        // A real exception hides a pending interrupt
        excp_ecode_o = excp_valid_i ? excp_ecode_i : ECODE_INT;
        if (branch_taken_i[0]) begin
            next_pc_o = branch_target0_i;
            flush_o   = 1'b1;
        end else if (branch_taken_i[1]) begin
            next_pc_o = branch_target1_i;
            flush_o   = 1'b1;
        end else if (excp_valid_i || has_int_i) begin
            // Refill vector only for a real TLB refill
            next_pc_o   = (excp_valid_i && excp_tlbrefill_i) ? tlbrentry_i : eentry_i;
            flush_o     = 1'b1;
            excp_take_o = 1'b1;
        end else if (ertn_i) begin
            next_pc_o   = era_i;
            flush_o     = 1'b1;
            ertn_take_o = 1'b1;
        end
    end

endmodule

// ==== rtl/commit_debug.sv ====
`timescale 1ns/10ps

module commit_debug (
    input  logic                               clk,
    input  logic                               rst_n_i,
    input  logic                               lane1_kill_i,
    input  logic                               wb0_we_i,
    input  logic [redirect_pkg::XLEN-1:0]      wb0_pc_i,
    input  logic [redirect_pkg::REG_NUM_W-1:0] wb0_wnum_i,
    input  logic [redirect_pkg::XLEN-1:0]      wb0_wdata_i,
    input  logic                               wb1_we_i,
    input  logic [redirect_pkg::XLEN-1:0]      wb1_pc_i,
    input  logic [redirect_pkg::REG_NUM_W-1:0] wb1_wnum_i,
    input  logic [redirect_pkg::XLEN-1:0]      wb1_wdata_i,
    output logic [redirect_pkg::XLEN-1:0]      debug0_wb_pc_o,
    output logic [3:0]                         debug0_wb_rf_wen_o,
    output logic [redirect_pkg::REG_NUM_W-1:0] debug0_wb_rf_wnum_o,
    output logic [redirect_pkg::XLEN-1:0]      debug0_wb_rf_wdata_o,
    output logic [redirect_pkg::XLEN-1:0]      debug1_wb_pc_o,
    output logic [3:0]                         debug1_wb_rf_wen_o,
    output logic [redirect_pkg::REG_NUM_W-1:0] debug1_wb_rf_wnum_o,
    output logic [redirect_pkg::XLEN-1:0]      debug1_wb_rf_wdata_o
);

    import redirect_pkg::*;

    logic wb0_commit;
    logic wb1_commit;

    // r0 is hardwired, and a killed lane 1 never retires
    assign wb0_commit = wb0_we_i && (wb0_wnum_i != '0);
    assign wb1_commit = wb1_we_i && (wb1_wnum_i != '0) && !lane1_kill_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            debug0_wb_rf_wen_o <= 4'b0000;
            debug1_wb_rf_wen_o <= 4'b0000;
        end else begin
            debug0_wb_rf_wen_o <= {3'b000, wb0_commit};
            debug1_wb_rf_wen_o <= {3'b000, wb1_commit};
        end
    end

    // Payload passes through as given
    always_ff @(posedge clk) begin
        debug0_wb_pc_o       <= wb0_pc_i;
        debug0_wb_rf_wnum_o  <= wb0_wnum_i;
        debug0_wb_rf_wdata_o <= wb0_wdata_i;
        debug1_wb_pc_o       <= wb1_pc_i;
        debug1_wb_rf_wnum_o  <= wb1_wnum_i;
        debug1_wb_rf_wdata_o <= wb1_wdata_i;
    end

endmodule

// ==== rtl/redirect_top.sv ====
`timescale 1ns/10ps

module redirect_top (
    input  logic                                 clk,
    input  logic                                 rst_n_i,
    input  logic [redirect_pkg::INT_NUM-1:0]     intrpt_i,
    input  logic [redirect_pkg::ISSUE_WIDTH-1:0] branch_taken_i,
    input  logic [redirect_pkg::XLEN-1:0]        branch_target0_i,
    input  logic [redirect_pkg::XLEN-1:0]        branch_target1_i,
    input  logic                                 excp_valid_i,
    input  logic [redirect_pkg::ECODE_W-1:0]     excp_ecode_i,
    input  logic                                 excp_tlbrefill_i,
    input  logic [redirect_pkg::XLEN-1:0]        excp_pc_i,
    input  logic                                 ertn_i,
    input  logic                                 csr_we_i,
    input  logic [redirect_pkg::CSR_ADDR_W-1:0]  csr_waddr_i,
    input  logic [redirect_pkg::XLEN-1:0]        csr_wdata_i,
    input  logic [redirect_pkg::CSR_ADDR_W-1:0]  csr_raddr_i,
    input  logic                                 wb0_we_i,
    input  logic [redirect_pkg::XLEN-1:0]        wb0_pc_i,
    input  logic [redirect_pkg::REG_NUM_W-1:0]   wb0_wnum_i,
    input  logic [redirect_pkg::XLEN-1:0]        wb0_wdata_i,
    input  logic                                 wb1_we_i,
    input  logic [redirect_pkg::XLEN-1:0]        wb1_pc_i,
    input  logic [redirect_pkg::REG_NUM_W-1:0]   wb1_wnum_i,
    input  logic [redirect_pkg::XLEN-1:0]        wb1_wdata_i,
    output logic [redirect_pkg::XLEN-1:0]        next_pc_o,
    output logic                                 flush_o,
    output logic [1:0]                           plv_o,
    output logic [redirect_pkg::XLEN-1:0]        csr_rdata_o,
    output logic [redirect_pkg::XLEN-1:0]        debug0_wb_pc_o,
    output logic [3:0]                           debug0_wb_rf_wen_o,
    output logic [redirect_pkg::REG_NUM_W-1:0]   debug0_wb_rf_wnum_o,
    output logic [redirect_pkg::XLEN-1:0]        debug0_wb_rf_wdata_o,
    output logic [redirect_pkg::XLEN-1:0]        debug1_wb_pc_o,
    output logic [3:0]                           debug1_wb_rf_wen_o,
    output logic [redirect_pkg::REG_NUM_W-1:0]   debug1_wb_rf_wnum_o,
    output logic [redirect_pkg::XLEN-1:0]        debug1_wb_rf_wdata_o
);

    import redirect_pkg::*;

    // CSR state feeding the selector
    logic               has_int;
    logic [XLEN-1:0]    eentry;
    logic [XLEN-1:0]    tlbrentry;
    logic [XLEN-1:0]    era;

    // Selector decisions back to the CSRs and the commit ports
    logic               excp_take;
    logic               ertn_take;
    logic [ECODE_W-1:0] take_ecode;
    logic               lane1_kill;

    redirect_csr redirect_csr_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .intrpt_i     (intrpt_i),
        .excp_take_i  (excp_take),
        .ertn_take_i  (ertn_take),
        .excp_ecode_i (take_ecode),
        .excp_pc_i    (excp_pc_i),
        .csr_we_i     (csr_we_i),
        .csr_waddr_i  (csr_waddr_i),
        .csr_wdata_i  (csr_wdata_i),
        .csr_raddr_i  (csr_raddr_i),
        .csr_rdata_o  (csr_rdata_o),
        .has_int_o    (has_int),
        .eentry_o     (eentry),
        .tlbrentry_o  (tlbrentry),
        .era_o        (era),
        .plv_o        (plv_o)
    );

    redirect_sel redirect_sel_i (
        .branch_taken_i   (branch_taken_i),
        .branch_target0_i (branch_target0_i),
        .branch_target1_i (branch_target1_i),
        .excp_valid_i     (excp_valid_i),
        .excp_ecode_i     (excp_ecode_i),
        .excp_tlbrefill_i (excp_tlbrefill_i),
        .ertn_i           (ertn_i),
        .has_int_i        (has_int),
        .eentry_i         (eentry),
        .tlbrentry_i      (tlbrentry),
        .era_i            (era),
        .next_pc_o        (next_pc_o),
        .flush_o          (flush_o),
        .excp_take_o      (excp_take),
        .ertn_take_o      (ertn_take),
        .excp_ecode_o     (take_ecode),
        .lane1_kill_o     (lane1_kill)
    );

    commit_debug commit_debug_i (
        .clk                  (clk),
        .rst_n_i              (rst_n_i),
        .lane1_kill_i         (lane1_kill),
        .wb0_we_i             (wb0_we_i),
        .wb0_pc_i             (wb0_pc_i),
        .wb0_wnum_i           (wb0_wnum_i),
        .wb0_wdata_i          (wb0_wdata_i),
        .wb1_we_i             (wb1_we_i),
        .wb1_pc_i             (wb1_pc_i),
        .wb1_wnum_i           (wb1_wnum_i),
        .wb1_wdata_i          (wb1_wdata_i),
        .debug0_wb_pc_o       (debug0_wb_pc_o),
        .debug0_wb_rf_wen_o   (debug0_wb_rf_wen_o),
        .debug0_wb_rf_wnum_o  (debug0_wb_rf_wnum_o),
        .debug0_wb_rf_wdata_o (debug0_wb_rf_wdata_o),
        .debug1_wb_pc_o       (debug1_wb_pc_o),
        .debug1_wb_rf_wen_o   (debug1_wb_rf_wen_o),
        .debug1_wb_rf_wnum_o  (debug1_wb_rf_wnum_o),
        .debug1_wb_rf_wdata_o (debug1_wb_rf_wdata_o)
    );

endmodule

// ==== dv/redirect_chk.sv ====
`timescale 1ns/10ps

module redirect_chk (
    input logic       clk,
    input logic       rst_n_i,
    input logic       excp_take_i,
    input logic       ertn_take_i,
    input logic       flush_i,
    input logic [1:0] plv_i
);

    int mutex_fails = 0;
    int flush_fails = 0;
    int plv_fails   = 0;

    // Only one redirect source can win a cycle
    take_exclusive_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(excp_take_i && ertn_take_i))
    else begin
        $error("exception and return taken in the same cycle");
        mutex_fails = mutex_fails + 1;
    end

    take_flush_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        (excp_take_i || ertn_take_i) |-> flush_i)
    else begin
        $error("take strobe without a backend flush");
        flush_fails = flush_fails + 1;
    end

    // Exception entry drops to kernel level
    excp_plv_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        excp_take_i |=> (plv_i == 2'b00))
    else begin
        $error("privilege level not zero after exception entry");
        plv_fails = plv_fails + 1;
    end

endmodule

bind redirect_top redirect_chk redirect_chk_i (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .excp_take_i (excp_take),
    .ertn_take_i (ertn_take),
    .flush_i     (flush_o),
    .plv_i       (plv_o)
);

// ==== dv/redirect_tb.sv ====
`timescale 1ns/10ps

module redirect_tb;

    import redirect_pkg::*;

    localparam int SEED           = 5;
    localparam int RESET_CYCLES   = 2;
    localparam int RUN_CYCLES     = 4000;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + RUN_CYCLES + 20;

    logic                   clk, rst_n_i, excp_valid_i, excp_tlbrefill_i, ertn_i, csr_we_i;
    logic [INT_NUM-1:0]     intrpt_i;
    logic [ISSUE_WIDTH-1:0] branch_taken_i;
    logic [XLEN-1:0]        branch_target0_i, branch_target1_i, excp_pc_i, csr_wdata_i;
    logic [ECODE_W-1:0]     excp_ecode_i;
    logic [CSR_ADDR_W-1:0]  csr_waddr_i, csr_raddr_i;
    logic                   wb0_we_i, wb1_we_i;
    logic [XLEN-1:0]        wb0_pc_i, wb0_wdata_i, wb1_pc_i, wb1_wdata_i;
    logic [REG_NUM_W-1:0]   wb0_wnum_i, wb1_wnum_i;
    logic [XLEN-1:0]        next_pc_o, csr_rdata_o;
    logic                   flush_o;
    logic [1:0]             plv_o;
    logic [XLEN-1:0]        debug0_wb_pc_o, debug0_wb_rf_wdata_o;
    logic [XLEN-1:0]        debug1_wb_pc_o, debug1_wb_rf_wdata_o;
    logic [3:0]             debug0_wb_rf_wen_o, debug1_wb_rf_wen_o;
    logic [REG_NUM_W-1:0]   debug0_wb_rf_wnum_o, debug1_wb_rf_wnum_o;

    // Reference CSR state
    logic [1:0]             m_crmd_plv, m_prmd_plv;
    logic                   m_crmd_ie, m_prmd_ie;
    logic [INT_NUM-1:0]     m_ecfg;
    logic [ECODE_W-1:0]     m_code;
    logic [XLEN-1:0]        m_era, m_eentry, m_tlbrentry;

    // Expected redirect and the registered debug lanes
    logic [XLEN-1:0]        exp_pc, exp_pc0, exp_pc1, exp_data0, exp_data1;
    logic                   exp_flush, take_e, take_r, has_int;
    logic [3:0]             exp_wen0, exp_wen1;
    logic [REG_NUM_W-1:0]   exp_wnum0, exp_wnum1;
    int                     n_errors, assert_errs, cycle_cnt;

    redirect_top redirect_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    task automatic report_fail(input string name, input logic [XLEN-1:0] exp_val,
                               input logic [XLEN-1:0] act_val);
        n_errors++;
        $display("Fail %s at cycle %0d: expected %h, actual %h",
                 name, cycle_cnt, exp_val, act_val);
    endtask

    // Seven real CSRs plus two unmapped addresses
    function automatic logic [CSR_ADDR_W-1:0] pick_addr(input logic [31:0] r);
        case (r % 9)
            0: return CSR_CRMD;
            1: return CSR_PRMD;
            2: return CSR_ECFG;
            3: return CSR_ESTAT;
            4: return CSR_ERA;
            5: return CSR_EENTRY;
            6: return CSR_TLBRENTRY;
            7: return 14'h003;
            default: return 14'h1234;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] model_read(input logic [CSR_ADDR_W-1:0] addr);
        case (addr)
            CSR_CRMD:      return {29'd0, m_crmd_ie, m_crmd_plv};
            CSR_PRMD:      return {29'd0, m_prmd_ie, m_prmd_plv};
            CSR_ECFG:      return {24'd0, m_ecfg};
            CSR_ESTAT:     return {10'd0, m_code, 6'd0, intrpt_i, 2'd0};
            CSR_ERA:       return m_era;
            CSR_EENTRY:    return m_eentry;
            CSR_TLBRENTRY: return m_tlbrentry;
            default:       return '0;
        endcase
    endfunction

    task automatic drive_random();
        // Branches rare, exceptions rarer
        branch_taken_i   = {($urandom % 8) == 0, ($urandom % 8) == 0};
        branch_target0_i = $urandom;
        branch_target1_i = $urandom;
        excp_valid_i     = ($urandom % 16) == 0;
        excp_ecode_i     = 6'($urandom);
        excp_tlbrefill_i = ($urandom % 2) == 0;
        excp_pc_i        = $urandom;
        ertn_i           = ($urandom % 12) == 0;
        intrpt_i         = (($urandom % 4) == 0) ? 8'(1 << ($urandom % 8)) : 8'h00;
        csr_we_i         = ($urandom % 2) == 0;
        csr_waddr_i      = pick_addr($urandom);
        csr_wdata_i      = $urandom;
        csr_raddr_i      = pick_addr($urandom);
        wb0_we_i         = ($urandom % 4) != 0;
        wb0_pc_i         = $urandom;
        wb0_wnum_i       = (($urandom % 8) == 0) ? 5'd0 : 5'($urandom);
        wb0_wdata_i      = $urandom;
        wb1_we_i         = ($urandom % 4) != 0;
        wb1_pc_i         = $urandom;
        wb1_wnum_i       = (($urandom % 8) == 0) ? 5'd0 : 5'($urandom);
        wb1_wdata_i      = $urandom;
    endtask

    task automatic model_redirect();
        has_int   = m_crmd_ie && (|(intrpt_i & m_ecfg));
        exp_flush = 1'b1;
        take_e    = 1'b0;
        take_r    = 1'b0;
        if (branch_taken_i[0]) begin
            exp_pc = branch_target0_i;
        end else if (branch_taken_i[1]) begin
            exp_pc = branch_target1_i;
        end else if (excp_valid_i || has_int) begin
            exp_pc = (excp_valid_i && excp_tlbrefill_i) ? m_tlbrentry : m_eentry;
            take_e = 1'b1;
        end else if (ertn_i) begin
            exp_pc = m_era;
            take_r = 1'b1;
        end else begin
            exp_pc    = '0;
            exp_flush = 1'b0;
        end
    endtask

    // State after the coming edge
    task automatic model_update();
        if (take_e) begin
            m_era      = excp_pc_i;
            m_prmd_plv = m_crmd_plv;
            m_prmd_ie  = m_crmd_ie;
            m_crmd_plv = 2'b00;
            m_crmd_ie  = 1'b0;
            m_code     = excp_valid_i ? excp_ecode_i : ECODE_INT;
        end else if (take_r) begin
            m_crmd_plv = m_prmd_plv;
            m_crmd_ie  = m_prmd_ie;
        end else if (csr_we_i) begin
            case (csr_waddr_i)
                CSR_CRMD:      {m_crmd_ie, m_crmd_plv} = csr_wdata_i[2:0];
                CSR_PRMD:      {m_prmd_ie, m_prmd_plv} = csr_wdata_i[2:0];
                CSR_ECFG:      m_ecfg = csr_wdata_i[INT_NUM-1:0];
                CSR_ERA:       m_era = csr_wdata_i;
                CSR_EENTRY:    m_eentry = csr_wdata_i;
                CSR_TLBRENTRY: m_tlbrentry = csr_wdata_i;
                default: ;
            endcase
        end
        exp_wen0  = {3'b000, wb0_we_i && (wb0_wnum_i != 5'd0)};
        exp_wen1  = {3'b000, wb1_we_i && (wb1_wnum_i != 5'd0) && !branch_taken_i[0]};
        exp_pc0   = wb0_pc_i;
        exp_pc1   = wb1_pc_i;
        exp_wnum0 = wb0_wnum_i;
        exp_wnum1 = wb1_wnum_i;
        exp_data0 = wb0_wdata_i;
        exp_data1 = wb1_wdata_i;
    endtask

    task automatic check_registered();
        if (plv_o !== m_crmd_plv) report_fail("plv", 32'(m_crmd_plv), 32'(plv_o));
        if (debug0_wb_rf_wen_o !== exp_wen0)
            report_fail("debug0_wen", 32'(exp_wen0), 32'(debug0_wb_rf_wen_o));
        if (debug1_wb_rf_wen_o !== exp_wen1)
            report_fail("debug1_wen", 32'(exp_wen1), 32'(debug1_wb_rf_wen_o));
        if (debug0_wb_pc_o !== exp_pc0) report_fail("debug0_pc", exp_pc0, debug0_wb_pc_o);
        if (debug1_wb_pc_o !== exp_pc1) report_fail("debug1_pc", exp_pc1, debug1_wb_pc_o);
        if (debug0_wb_rf_wnum_o !== exp_wnum0)
            report_fail("debug0_wnum", 32'(exp_wnum0), 32'(debug0_wb_rf_wnum_o));
        if (debug1_wb_rf_wnum_o !== exp_wnum1)
            report_fail("debug1_wnum", 32'(exp_wnum1), 32'(debug1_wb_rf_wnum_o));
        if (debug0_wb_rf_wdata_o !== exp_data0)
            report_fail("debug0_wdata", exp_data0, debug0_wb_rf_wdata_o);
        if (debug1_wb_rf_wdata_o !== exp_data1)
            report_fail("debug1_wdata", exp_data1, debug1_wb_rf_wdata_o);
    endtask

    initial begin
        void'($urandom(SEED));
        n_errors  = 0;
        rst_n_i   = 1'b0;
        {intrpt_i, branch_taken_i, branch_target0_i, branch_target1_i, excp_valid_i,
         excp_ecode_i, excp_tlbrefill_i, excp_pc_i, ertn_i, csr_we_i, csr_waddr_i,
         csr_wdata_i, csr_raddr_i, wb0_we_i, wb0_pc_i, wb0_wnum_i, wb0_wdata_i,
         wb1_we_i, wb1_pc_i, wb1_wnum_i, wb1_wdata_i} = '0;
        {m_crmd_plv, m_prmd_plv, m_crmd_ie, m_prmd_ie, m_ecfg, m_code} = '0;
        {m_era, m_eentry, m_tlbrentry} = '0;
        {exp_wen0, exp_wen1, exp_pc0, exp_pc1, exp_wnum0, exp_wnum1} = '0;
        {exp_data0, exp_data1} = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        repeat (RUN_CYCLES) begin
            check_registered();
            drive_random();
            #2;
            model_redirect();
            if (next_pc_o !== exp_pc) report_fail("next_pc", exp_pc, next_pc_o);
            if (flush_o !== exp_flush) report_fail("flush", 32'(exp_flush), 32'(flush_o));
            if (csr_rdata_o !== model_read(csr_raddr_i))
                report_fail("csr_rdata", model_read(csr_raddr_i), csr_rdata_o);
            model_update();
            @(negedge clk);
        end
        // Registered results of the last stimulus cycle
        check_registered();
        assert_errs = redirect_top_i.redirect_chk_i.mutex_fails
                    + redirect_top_i.redirect_chk_i.flush_fails
                    + redirect_top_i.redirect_chk_i.plv_fails;
        $display("Summary: %0d cycles, %0d check errors, %0d assertion errors",
                 RUN_CYCLES, n_errors, assert_errs);
        if (n_errors == 0 && assert_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== redirect_top.f ====
rtl/redirect_pkg.sv
rtl/redirect_csr.sv
rtl/redirect_sel.sv
rtl/commit_debug.sv
rtl/redirect_top.sv
dv/redirect_chk.sv
dv/redirect_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        = redirect_tb
FILELIST   = redirect_top.f
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
RUN_ARGS   = +verilator+error+limit+1000
OBJ_DIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
